// ==== hdl/press_count_pkg.sv ====
package press_count_pkg;

    //////////////////////////////
    // Display geometry
    //////////////////////////////
    localparam int NUM_DIGITS  = 8;
    localparam int DIGIT_W     = 4;
    localparam int SEG_W       = 7;
    localparam int DIGIT_SEL_W = $clog2(NUM_DIGITS);

    // Largest decimal digit value
    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 4'd9;

    // About 10 ms of stable level at 100 MHz
    localparam int PB_DELAY_DEFAULT = 1_000_000;
    // About 1 ms per digit at 100 MHz
    localparam int SCAN_DEFAULT     = 100_000;

    // Eight BCD digits, digit 0 is the least significant
    typedef logic [NUM_DIGITS-1:0][DIGIT_W-1:0] bcd_count_t;

    // Display pins, all active low
    typedef struct packed {
        logic [SEG_W-1:0]      segments;  // {CA, CB, CC, CD, CE, CF, CG}
        logic [NUM_DIGITS-1:0] anodos;    // {AN7 .. AN0}
    } seg_disp_t;

    // Digit value to active-low segment pattern
    function automatic logic [SEG_W-1:0] seg7_encode(input logic [DIGIT_W-1:0] value);
        case (value)
            4'h0: return 7'b0000001;
            4'h1: return 7'b1001111;
            4'h2: return 7'b0010010;
            4'h3: return 7'b0000110;
            4'h4: return 7'b1001100;
            4'h5: return 7'b0100100;
            4'h6: return 7'b0100000;
            4'h7: return 7'b0001111;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0000100;
            // Hex letters, not reached by the BCD counter
            4'ha: return 7'b0001000;
            4'hb: return 7'b1100000;
            4'hc: return 7'b0110001;
            4'hd: return 7'b1000010;
            4'he: return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

endpackage

// ==== hdl/pb_debouncer.sv ====
`timescale 1ns/1ns

module pb_debouncer #(
    parameter int PB_DELAY = press_count_pkg::PB_DELAY_DEFAULT
) (
    input  logic clock,
    input  logic rst,
    input  logic btn,
    output logic press
);

    // Two-flop synchronizer stages
    logic [1:0] sync_q;
    logic       btn_sync;

    // Accepted button level and its copy one cycle back
    logic stable;
    logic stable_prev;

    // Cycles the input has disagreed with the stable level
    logic [$clog2(PB_DELAY+1)-1:0] hold_cnt;
    logic                          differ;
    logic                          hold_done;

    //////////////////////////////
    // Synchronizer
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], btn};
        end
    end

    assign btn_sync = sync_q[1];

    //////////////////////////////
    // Stability filter
    //////////////////////////////
    assign differ    = (btn_sync != stable);
    // Last disagreeing cycle of the window
    assign hold_done = (hold_cnt == $bits(hold_cnt)'(PB_DELAY - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            hold_cnt <= '0;
            stable   <= 1'b0;
        end else if (!differ) begin
            // Bounce back to the old level restarts the window
            hold_cnt <= '0;
        end else if (hold_done) begin
            // New level held long enough
            stable   <= btn_sync;
            hold_cnt <= '0;
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Rising edge pulse
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            stable_prev <= 1'b0;
            press       <= 1'b0;
        end else begin
            stable_prev <= stable;
            // Only 0 to 1 transitions count as a press
            press       <= stable & ~stable_prev;
        end
    end

endmodule

// ==== hdl/bcd_press_counter.sv ====
`timescale 1ns/1ns

module bcd_press_counter (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        count_clr,
    input  logic                        press,
    output press_count_pkg::bcd_count_t count
);

    // Increment request arriving at each digit
    logic [press_count_pkg::NUM_DIGITS-1:0] carry;
    // Digit currently at nine
    logic [press_count_pkg::NUM_DIGITS-1:0] at_nine;

    press_count_pkg::bcd_count_t count_nxt;

    //////////////////////////////
    // Ripple carry between digits
    //////////////////////////////
    assign carry[0] = press;

    for (genvar i = 0; i < press_count_pkg::NUM_DIGITS; i++) begin : g_digit

        assign at_nine[i] = (count[i] == press_count_pkg::DIGIT_MAX);

        // Carry from the digit below
        if (i > 0) begin : g_carry
            assign carry[i] = carry[i-1] & at_nine[i-1];
        end

        always_comb begin
            if (!carry[i]) begin
                count_nxt[i] = count[i];
            end else if (at_nine[i]) begin
                // Nine rolls to zero, carry goes up
                count_nxt[i] = '0;
            end else begin
                count_nxt[i] = count[i] + 1'b1;
            end
        end

    end

    //////////////////////////////
    // Count register
    //////////////////////////////
    // Top digit at nine simply rolls over, so 99999999 wraps to 0
    always_ff @(posedge clock) begin
        if (rst || count_clr) begin
            // Held clear also drops any press
            count <= '0;
        end else begin
            count <= count_nxt;
        end
    end

endmodule

// ==== hdl/seg7_scanner.sv ====
`timescale 1ns/1ns

module seg7_scanner #(
    parameter int DISPLAY_COUNTER = press_count_pkg::SCAN_DEFAULT
) (
    input  logic                        clock,
    input  logic                        rst,
    input  press_count_pkg::bcd_count_t count,
    output press_count_pkg::seg_disp_t  disp
);

    // Refresh divider
    logic [$clog2(DISPLAY_COUNTER+1)-1:0] refresh_cnt;
    logic                                 tick;

    // Selected digit, now and after this edge
    logic [press_count_pkg::DIGIT_SEL_W-1:0] digit_sel;
    logic [press_count_pkg::DIGIT_SEL_W-1:0] digit_sel_nxt;

    // Value and pins of the digit about to be shown
    logic [press_count_pkg::DIGIT_W-1:0]    digit_val;
    logic [press_count_pkg::NUM_DIGITS-1:0] anode_n;
    press_count_pkg::seg_disp_t             disp_nxt;

    //////////////////////////////
    // Refresh divider
    //////////////////////////////
    // One tick per DISPLAY_COUNTER cycles
    assign tick = (refresh_cnt == $bits(refresh_cnt)'(DISPLAY_COUNTER - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            refresh_cnt <= '0;
        end else if (tick) begin
            refresh_cnt <= '0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // Digit select
    //////////////////////////////
    // Index wraps naturally from 7 back to 0
    assign digit_sel_nxt = tick ? digit_sel + 1'b1 : digit_sel;

    always_ff @(posedge clock) begin
        if (rst) begin
            digit_sel <= '0;
        end else begin
            digit_sel <= digit_sel_nxt;
        end
    end

    //////////////////////////////
    // Digit mux and encoding
    //////////////////////////////
    // Look ahead to the next index so pins and index move on the same edge
    assign digit_val = count[digit_sel_nxt];

    always_comb begin
        // One-hot zero anode for the selected digit
        anode_n                = '1;
        anode_n[digit_sel_nxt] = 1'b0;
    end

    always_comb begin
        disp_nxt.segments = press_count_pkg::seg7_encode(digit_val);
        disp_nxt.anodos   = anode_n;
    end

    //////////////////////////////
    // Output register
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            // Digit 0 showing a zero
            disp.segments <= press_count_pkg::seg7_encode('0);
            disp.anodos   <= {{(press_count_pkg::NUM_DIGITS-1){1'b1}}, 1'b0};
        end else begin
            // Segments and anode always change together
            disp <= disp_nxt;
        end
    end

endmodule

// ==== hdl/press_counter_top.sv ====
`timescale 1ns/1ns

module press_counter_top #(
    parameter int PB_DELAY        = press_count_pkg::PB_DELAY_DEFAULT,
    parameter int DISPLAY_COUNTER = press_count_pkg::SCAN_DEFAULT
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                btn,
    input  logic                                count_clr,
    output logic [press_count_pkg::SEG_W-1:0]      segments,
    output logic [press_count_pkg::NUM_DIGITS-1:0] anodos
);

    // One-cycle press strobe
    logic press;
    // Eight BCD digits
    press_count_pkg::bcd_count_t count;
    // Registered display pins
    press_count_pkg::seg_disp_t  disp;

    // Button cleanup
    pb_debouncer #(
        .PB_DELAY(PB_DELAY)
    ) u_debouncer (
        .clock(clock),
        .rst  (rst),
        .btn  (btn),
        .press(press)
    );

    // Decimal press count
    bcd_press_counter u_counter (
        .clock    (clock),
        .rst      (rst),
        .count_clr(count_clr),
        .press    (press),
        .count    (count)
    );

    // Multiplexed display drive
    seg7_scanner #(
        .DISPLAY_COUNTER(DISPLAY_COUNTER)
    ) u_scanner (
        .clock(clock),
        .rst  (rst),
        .count(count),
        .disp (disp)
    );

    // Split the display struct onto the pins
    assign segments = disp.segments;
    assign anodos   = disp.anodos;

endmodule

// ==== dv/press_counter_tb.sv ====
`timescale 1ns/1ns

module press_counter_tb;

    localparam int PB_DELAY   = 5;
    localparam int SCAN       = 20;
    // Longer than synchronizer plus filter window
    localparam int PRESS_HOLD = 2 + PB_DELAY + 2;
    localparam int FRAME      = press_count_pkg::NUM_DIGITS * SCAN;
    localparam logic [31:0] SEED = 32'h2c3eec61;

    logic                                   clock;
    logic                                   rst;
    logic                                   btn;
    logic                                   count_clr;
    logic [press_count_pkg::SEG_W-1:0]      segments;
    logic [press_count_pkg::NUM_DIGITS-1:0] anodos;

    logic [31:0] lfsr_state;
    // Count the display should show
    int          expected;

    press_counter_top #(
        .PB_DELAY       (PB_DELAY),
        .DISPLAY_COUNTER(SCAN)
    ) UUT (
        .clock    (clock),
        .rst      (rst),
        .btn      (btn),
        .count_clr(count_clr),
        .segments (segments),
        .anodos   (anodos)
    );

    always #20 clock = ~clock;

    //////////////////////////////
    // Random source
    //////////////////////////////
    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    //////////////////////////////
    // Checking helpers
    //////////////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expect_val);
        if (actual !== expect_val) begin
            $display("ERR %0t %s actual=%0h expected=%0h", $time, name, actual, expect_val);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // Segment pattern back to a decimal digit, -1 if none matches
    function automatic int decode_digit(input logic [press_count_pkg::SEG_W-1:0] seg);
        int v;
        v = -1;
        for (int d = 0; d < 10; d++) begin
            if (seg == press_count_pkg::seg7_encode(4'(d))) begin
                v = d;
            end
        end
        return v;
    endfunction

    // Cycles an anode pattern stays on the pins, counting the current sample
    task automatic measure_digit(input logic [7:0] pattern, output int hold);
        hold = 0;
        while (anodos == pattern) begin
            hold++;
            @(negedge clock);
            if (hold > 2 * SCAN) begin
                timeout_fail("anode pattern never moved to the next digit");
            end
        end
    endtask

    task automatic read_display(output int value);
        logic [7:0] prev;
        logic [7:0] pattern;
        int         wait_cnt;
        int         hold;
        int         digit;
        int         scale;
        // Sync on AN7 handing over to AN0
        prev     = anodos;
        wait_cnt = 0;
        @(negedge clock);
        while (!(prev == 8'h7f && anodos == 8'hfe)) begin
            prev = anodos;
            @(negedge clock);
            wait_cnt++;
            if (wait_cnt > 2 * FRAME) begin
                timeout_fail("no frame start seen on anodos");
            end
        end
        value = 0;
        scale = 1;
        for (int d = 0; d < press_count_pkg::NUM_DIGITS; d++) begin
            pattern = ~(8'h01 << d);
            check_value("active anodes", $countones(~anodos), 1);
            check_value("anodos", anodos, pattern);
            digit = decode_digit(segments);
            if (digit < 0) begin
                $display("Segments %b at %0t match no decimal digit", segments, $time);
                $display("** FAIL **");
                $fatal(1);
            end
            measure_digit(pattern, hold);
            check_value("digit hold cycles", hold, SCAN);
            value += digit * scale;
            scale *= 10;
        end
    endtask

    task automatic expect_display(input string name);
        int shown;
        read_display(shown);
        check_value(name, shown, expected);
    endtask

    //////////////////////////////
    // Button stimulus
    //////////////////////////////
    task automatic press_clean();
        btn = 1'b1;
        repeat (PRESS_HOLD) @(negedge clock);
        btn = 1'b0;
        repeat (PRESS_HOLD) @(negedge clock);
        // Held clear drops the press
        if (!count_clr) begin
            expected = (expected + 1) % 100_000_000;
        end
    endtask

    // Short toggles below PB_DELAY, then a settled press
    task automatic press_bouncy();
        int toggles;
        toggles = 1 + rand_bits(3);
        for (int t = 0; t < toggles; t++) begin
            btn = ~btn;
            repeat (1 + rand_bits(2)) @(negedge clock);
        end
        press_clean();
    endtask

    task automatic glitch_pulse();
        btn = 1'b1;
        repeat (1 + rand_bits(2)) @(negedge clock);
        btn = 1'b0;
        repeat (PRESS_HOLD) @(negedge clock);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    task automatic test_reset_display();
        expected = 0;
        expect_display("display after reset");
    endtask

    task automatic test_clean_presses();
        int n;
        n = 1 + rand_bits(5) % 30;
        repeat (n) press_clean();
        expect_display("display after clean presses");
    endtask

    task automatic test_bounce();
        int n;
        n = 1 + rand_bits(3);
        repeat (n) press_bouncy();
        // Glitches alone never settle
        repeat (3) glitch_pulse();
        expect_display("display after bouncing presses");
    endtask

    task automatic test_clear();
        count_clr = 1'b1;
        @(negedge clock);
        expected = 0;
        repeat (3) press_clean();
        expect_display("display under clear");
        count_clr = 1'b0;
        repeat (2) press_clean();
        expect_display("display after clear release");
    endtask

    task automatic test_carry();
        int targets[6] = '{9, 10, 99, 100, 109, 110};
        count_clr = 1'b1;
        @(negedge clock);
        count_clr = 1'b0;
        expected  = 0;
        foreach (targets[i]) begin
            while (expected < targets[i]) begin
                press_clean();
            end
            expect_display("display across carry");
        end
    endtask

    task automatic test_mid_reset();
        int hold;
        repeat (2) press_clean();
        // Land somewhere inside a frame
        repeat (1 + rand_bits(6)) @(negedge clock);
        rst = 1'b1;
        repeat (2) @(negedge clock);
        rst      = 1'b0;
        expected = 0;
        check_value("anodos after reset", anodos, 8'hfe);
        check_value("segments after reset", segments, press_count_pkg::seg7_encode(4'd0));
        measure_digit(8'hfe, hold);
        check_value("first digit hold after reset", hold, SCAN);
        expect_display("display after mid-run reset");
    endtask

    initial begin
        clock      = 1'b0;
        rst        = 1'b1;
        btn        = 1'b0;
        count_clr  = 1'b0;
        lfsr_state = SEED;
        expected   = 0;
        repeat (2) @(negedge clock);
        rst = 1'b0;
        test_reset_display();
        test_clean_presses();
        test_bounce();
        test_clear();
        test_carry();
        test_mid_reset();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/press_count_pkg.sv
hdl/pb_debouncer.sv
hdl/bcd_press_counter.sv
hdl/seg7_scanner.sv
hdl/press_counter_top.sv
dv/press_counter_tb.sv
